// ==== hdl/cpuIsaPkg.sv ====
// Instruction set of the cut-down 6502 core
// Opcode encodings, execute states, ALU operations and status bit positions
`default_nettype none

package cpuIsaPkg;

	// Kept opcodes, standard NMOS 6502 encodings
	typedef enum logic [7:0] {
		LDA_IMM = 8'hA9,
		LDX_IMM = 8'hA2,
		LDY_IMM = 8'hA0,
		ADC_IMM = 8'h69,
		SBC_IMM = 8'hE9,
		AND_IMM = 8'h29,
		ORA_IMM = 8'h09,
		EOR_IMM = 8'h49,
		CMP_IMM = 8'hC9,
		INX     = 8'hE8,
		INY     = 8'hC8,
		DEX     = 8'hCA,
		DEY     = 8'h88,
		TAX     = 8'hAA,
		TAY     = 8'hA8,
		TXA     = 8'h8A,
		TYA     = 8'h98,
		CLC     = 8'h18,
		SEC     = 8'h38,
		CLV     = 8'hB8,
		NOP     = 8'hEA,
		STA_ZP  = 8'h85,
		STX_ZP  = 8'h86,
		STY_ZP  = 8'h84
	} opcode_t;

	typedef enum logic [1:0] {
		sOpcode,
		sOperand,
		sWriteback
	} execState_t;

	typedef enum logic [2:0] {
		opAdc,
		opSbc,
		opAnd,
		opOra,
		opEor,
		opInc,
		opDec,
		opPass
	} aluOp_t;

	// Status register bit positions
	localparam int FlagN = 7;
	localparam int FlagV = 6;
	localparam int FlagZ = 1;
	localparam int FlagC = 0;

endpackage

`default_nettype wire

// ==== hdl/cpuBusPkg.sv ====
// Memory side of the core
// Bus widths, reset vector location and status value after reset
`default_nettype none

package cpuBusPkg;

	localparam int AddrWidth = 16;
	localparam int DataWidth = 8;

	// Low vector byte, high byte sits at the next address
	localparam logic [AddrWidth-1:0] ResetVectorLo = 16'hFFFC;

	// I and Z set, bit 4 reads back as one
	localparam logic [DataWidth-1:0] StatusReset = 8'h16;

endpackage

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
// Fetch unit
// Reads the reset vector, then streams sequential instruction bytes
// into the prefetch queue while it holds credits
`default_nettype none

module fetchUnit
	import cpuBusPkg::*;
#(
	parameter int QueueDepth = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 fetchReq,
	output logic [AddrWidth-1:0] fetchAddr,
	input  logic [DataWidth-1:0] fetchData,
	output logic                 push,
	output logic [DataWidth-1:0] pushData,
	input  logic                 creditReturn
);

	localparam int CreditWidth = $clog2(QueueDepth + 1);

	typedef enum logic [1:0] {
		phVecLo,
		phVecHi,
		phRun
	} phase_t;

	phase_t                 phase;
	logic                   vecReq;
	logic                   hiPending;
	logic                   seqPending;
	logic                   runReq;
	logic [DataWidth-1:0]   vecLo;
	logic [AddrWidth-1:0]   addrReg;
	logic [CreditWidth-1:0] credits;

	// A credit returned this cycle can be spent at once
	assign runReq = (phase == phRun) && ((credits != '0) || creditReturn);

	assign fetchReq = vecReq | runReq;

	// First run cycle takes its address straight from the high vector byte
	assign fetchAddr = hiPending ? {fetchData, vecLo} : addrReg;

	// Only bytes from sequential requests go to the queue
	assign push     = seqPending;
	assign pushData = fetchData;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase      <= phVecLo;
			vecReq     <= 1'b0;
			hiPending  <= 1'b0;
			seqPending <= 1'b0;
			addrReg    <= ResetVectorLo;
			credits    <= CreditWidth'(QueueDepth);
		end else begin
			seqPending <= runReq;
			hiPending  <= (phase == phVecHi);
			credits    <= credits - CreditWidth'(runReq) + CreditWidth'(creditReturn);
			case (phase)
				phVecLo: begin
					if (vecReq) begin
						phase   <= phVecHi;
						addrReg <= ResetVectorLo + AddrWidth'(1);
					end else begin
						vecReq <= 1'b1;
					end
				end
				phVecHi: begin
					vecReq <= 1'b0;
					phase  <= phRun;
				end
				default: begin
					// Hold the address while out of credits
					addrReg <= fetchAddr + AddrWidth'(runReq);
				end
			endcase
		end
	end

	// Low vector byte returns during the high byte request
	always_ff @(posedge clk) begin
		if (phase == phVecHi)
			vecLo <= fetchData;
	end

endmodule

`default_nettype wire

// ==== hdl/prefetchQueue.sv ====
// Prefetch queue
// Circular byte buffer between fetch and execute, returns one credit
// to the fetch unit for every byte popped
`default_nettype none

module prefetchQueue
	import cpuBusPkg::*;
#(
	parameter int QueueDepth = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 push,
	input  logic [DataWidth-1:0] pushData,
	input  logic                 pop,
	output logic [DataWidth-1:0] headData,
	output logic                 notEmpty,
	output logic                 creditReturn
);

	localparam int PtrWidth   = $clog2(QueueDepth);
	localparam int CountWidth = $clog2(QueueDepth + 1);
	localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(QueueDepth - 1);

	logic [DataWidth-1:0]  mem [QueueDepth];
	logic [PtrWidth-1:0]   wrPtr;
	logic [PtrWidth-1:0]   rdPtr;
	logic [CountWidth-1:0] count;

	assign headData = mem[rdPtr];
	assign notEmpty = (count != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			creditReturn <= 1'b0;
		end else begin
			// Pointers wrap at any depth, not only powers of two
			if (push)
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + PtrWidth'(1);
			if (pop)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + PtrWidth'(1);
			count <= count + CountWidth'(push) - CountWidth'(pop);
			// Registered so no combinational path closes the credit loop
			creditReturn <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// ALU
// Combinational 8-bit unit for binary add and subtract with carry,
// logic operations, increment, decrement and pass-through
`default_nettype none

module alu
	import cpuIsaPkg::*;
	import cpuBusPkg::*;
(
	input  aluOp_t               op,
	input  logic [DataWidth-1:0] a,
	input  logic [DataWidth-1:0] b,
	input  logic                 carryIn,
	output logic [DataWidth-1:0] result,
	output logic                 carryOut,
	output logic                 overflow
);

	localparam int Msb = DataWidth - 1;

	logic [DataWidth-1:0] addend;
	logic [DataWidth:0]   sum;

	// Subtract is an add of the inverted operand, carry acts as not-borrow
	assign addend = (op == opSbc) ? ~b : b;
	assign sum    = {1'b0, a} + {1'b0, addend} + {{DataWidth{1'b0}}, carryIn};

	always_comb begin
		result   = a;
		carryOut = carryIn;
		overflow = 1'b0;
		case (op)
			opAdc, opSbc: begin
				result   = sum[Msb:0];
				carryOut = sum[DataWidth];
				// Signed overflow when both inputs agree in sign and the result does not
				overflow = (a[Msb] == addend[Msb]) && (sum[Msb] != a[Msb]);
			end
			opAnd:
				result = a & b;
			opOra:
				result = a | b;
			opEor:
				result = a ^ b;
			opInc:
				result = a + DataWidth'(1);
			opDec:
				result = a - DataWidth'(1);
			default:
				result = b;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/execUnit.sv ====
// Execute unit
// Pops instruction bytes from the prefetch queue, decodes and executes
// them, and holds A, X, Y and the status register
`default_nettype none

module execUnit
	import cpuIsaPkg::*;
	import cpuBusPkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [DataWidth-1:0] headData,
	input  logic                 notEmpty,
	output logic                 pop,
	output logic                 memWrite,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWData,
	output logic                 sync,
	output logic [DataWidth-1:0] accDbg,
	output logic [DataWidth-1:0] xDbg,
	output logic [DataWidth-1:0] yDbg,
	output logic [DataWidth-1:0] statusDbg
);

	execState_t           state;
	execState_t           stateNext;
	logic [DataWidth-1:0] opReg;
	logic [DataWidth-1:0] curOp;
	logic [DataWidth-1:0] acc;
	logic [DataWidth-1:0] xReg;
	logic [DataWidth-1:0] yReg;
	logic [DataWidth-1:0] status;
	logic [DataWidth-1:0] srcReg;
	logic [DataWidth-1:0] aluB;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] aluResReg;
	logic [DataWidth-1:0] wrVal;
	logic                 aluCarry;
	logic                 aluOverflow;
	logic                 aluCReg;
	logic                 aluVReg;
	logic                 fire;
	logic                 complete;

	// Decoded controls
	aluOp_t aluOp;
	logic   twoByte;
	logic   storeOp;
	logic   aluImm;
	logic   forceCarry;
	logic   srcX;
	logic   srcY;
	logic   wrA;
	logic   wrX;
	logic   wrY;
	logic   updNZ;
	logic   updC;
	logic   updV;
	logic   setC;
	logic   clrC;
	logic   clrV;

	// Opcode comes from the queue head until it has been registered
	assign curOp = (state == sOpcode) ? headData : opReg;

	always_comb begin
		aluOp      = opPass;
		twoByte    = 1'b0;
		storeOp    = 1'b0;
		aluImm     = 1'b0;
		forceCarry = 1'b0;
		srcX       = 1'b0;
		srcY       = 1'b0;
		wrA        = 1'b0;
		wrX        = 1'b0;
		wrY        = 1'b0;
		updNZ      = 1'b0;
		updC       = 1'b0;
		updV       = 1'b0;
		setC       = 1'b0;
		clrC       = 1'b0;
		clrV       = 1'b0;
		case (opcode_t'(curOp))
			LDA_IMM: {twoByte, wrA, updNZ} = 3'b111;
			LDX_IMM: {twoByte, wrX, updNZ} = 3'b111;
			LDY_IMM: {twoByte, wrY, updNZ} = 3'b111;
			ADC_IMM: begin
				aluOp = opAdc;
				{twoByte, aluImm, wrA, updNZ, updC, updV} = 6'b111111;
			end
			SBC_IMM: begin
				aluOp = opSbc;
				{twoByte, aluImm, wrA, updNZ, updC, updV} = 6'b111111;
			end
			AND_IMM: begin
				aluOp = opAnd;
				{twoByte, aluImm, wrA, updNZ} = 4'b1111;
			end
			ORA_IMM: begin
				aluOp = opOra;
				{twoByte, aluImm, wrA, updNZ} = 4'b1111;
			end
			EOR_IMM: begin
				aluOp = opEor;
				{twoByte, aluImm, wrA, updNZ} = 4'b1111;
			end
			// Compare is a subtract with borrow clear and the result dropped
			CMP_IMM: begin
				aluOp = opSbc;
				{twoByte, aluImm, forceCarry, updNZ, updC} = 5'b11111;
			end
			INX: begin
				aluOp = opInc;
				{srcX, wrX, updNZ} = 3'b111;
			end
			INY: begin
				aluOp = opInc;
				{srcY, wrY, updNZ} = 3'b111;
			end
			DEX: begin
				aluOp = opDec;
				{srcX, wrX, updNZ} = 3'b111;
			end
			DEY: begin
				aluOp = opDec;
				{srcY, wrY, updNZ} = 3'b111;
			end
			TAX: {wrX, updNZ} = 2'b11;
			TAY: {wrY, updNZ} = 2'b11;
			TXA: {srcX, wrA, updNZ} = 3'b111;
			TYA: {srcY, wrA, updNZ} = 3'b111;
			CLC: clrC = 1'b1;
			SEC: setC = 1'b1;
			CLV: clrV = 1'b1;
			STA_ZP: {twoByte, storeOp} = 2'b11;
			STX_ZP: {twoByte, storeOp, srcX} = 3'b111;
			STY_ZP: {twoByte, storeOp, srcY} = 3'b111;
			// NOP and anything unknown fall through as a one-byte no-op
			default: ;
		endcase
	end

	assign srcReg = srcX ? xReg : (srcY ? yReg : acc);
	assign aluB   = (state == sOperand) ? headData : srcReg;

	alu alu_inst (
		.op       (aluOp),
		.a        (srcReg),
		.b        (aluB),
		.carryIn  (forceCarry | status[FlagC]),
		.result   (aluResult),
		.carryOut (aluCarry),
		.overflow (aluOverflow)
	);

	assign fire = notEmpty && (state != sWriteback);
	assign pop  = fire;

	always_comb begin
		stateNext = state;
		complete  = 1'b0;
		case (state)
			sOpcode: begin
				if (fire && twoByte)
					stateNext = sOperand;
				complete = fire && !twoByte;
			end
			sOperand: begin
				if (fire)
					stateNext = aluImm ? sWriteback : sOpcode;
				complete = fire && !aluImm;
			end
			default: begin
				stateNext = sOpcode;
				complete  = 1'b1;
			end
		endcase
	end

	// Zero page store happens in the operand pop cycle
	assign memWrite = (state == sOperand) && fire && storeOp;
	assign memAddr  = {{(AddrWidth - DataWidth){1'b0}}, headData};
	assign memWData = srcReg;

	assign wrVal = (state == sWriteback) ? aluResReg : aluResult;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= sOpcode;
			acc    <= '0;
			xReg   <= '0;
			yReg   <= '0;
			status <= StatusReset;
			sync   <= 1'b0;
		end else begin
			state <= stateNext;
			sync  <= complete;
			if (complete) begin
				if (wrA)
					acc <= wrVal;
				if (wrX)
					xReg <= wrVal;
				if (wrY)
					yReg <= wrVal;
				if (updNZ) begin
					status[FlagN] <= wrVal[DataWidth-1];
					status[FlagZ] <= (wrVal == '0);
				end
				// C and V only change at writeback or by flag instructions
				if (updC)
					status[FlagC] <= aluCReg;
				if (updV)
					status[FlagV] <= aluVReg;
				if (setC | clrC)
					status[FlagC] <= setC;
				if (clrV)
					status[FlagV] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == sOpcode && fire)
			opReg <= headData;
		if (state == sOperand && fire) begin
			aluResReg <= aluResult;
			aluCReg   <= aluCarry;
			aluVReg   <= aluOverflow;
		end
	end

	assign accDbg    = acc;
	assign xDbg      = xReg;
	assign yDbg      = yReg;
	assign statusDbg = status;

endmodule

`default_nettype wire

// ==== hdl/cpuCore.sv ====
// Cut-down NMOS 6502 core
// Fetch unit, prefetch queue and execute unit joined by credit flow control
`default_nettype none

module cpuCore
	import cpuBusPkg::*;
#(
	parameter int QueueDepth = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 fetchReq,
	output logic [AddrWidth-1:0] fetchAddr,
	input  logic [DataWidth-1:0] fetchData,
	output logic                 memWrite,
	output logic [AddrWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWData,
	output logic                 sync,
	output logic [DataWidth-1:0] accDbg,
	output logic [DataWidth-1:0] xDbg,
	output logic [DataWidth-1:0] yDbg,
	output logic [DataWidth-1:0] statusDbg
);

	logic                 push;
	logic [DataWidth-1:0] pushData;
	logic                 pop;
	logic [DataWidth-1:0] headData;
	logic                 notEmpty;
	logic                 creditReturn;

	fetchUnit #(
		.QueueDepth (QueueDepth)
	) fetchUnit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetchReq     (fetchReq),
		.fetchAddr    (fetchAddr),
		.fetchData    (fetchData),
		.push         (push),
		.pushData     (pushData),
		.creditReturn (creditReturn)
	);

	prefetchQueue #(
		.QueueDepth (QueueDepth)
	) prefetchQueue_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.push         (push),
		.pushData     (pushData),
		.pop          (pop),
		.headData     (headData),
		.notEmpty     (notEmpty),
		.creditReturn (creditReturn)
	);

	execUnit execUnit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.headData  (headData),
		.notEmpty  (notEmpty),
		.pop       (pop),
		.memWrite  (memWrite),
		.memAddr   (memAddr),
		.memWData  (memWData),
		.sync      (sync),
		.accDbg    (accDbg),
		.xDbg      (xDbg),
		.yDbg      (yDbg),
		.statusDbg (statusDbg)
	);

endmodule

`default_nettype wire

// ==== dv/cpuCore_checker.sv ====
// Credit protocol checker
// Watches queue occupancy, fetch credits and pops inside cpuCore
`default_nettype none

module cpuCore_checker #(
	parameter int QueueDepth = 4
) (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              push,
	input logic                              pop,
	input logic                              notEmpty,
	input logic [$clog2(QueueDepth + 1)-1:0] count,
	input logic [$clog2(QueueDepth + 1)-1:0] credits
);

	timeunit 1ns;
	timeprecision 1ps;

	int occupancy;
	int failCount = 0;

	// Bytes held by the queue, tracked from its push and pop strobes alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(push) - int'(pop);
	end

	// Queue has no full flag, so the credits must keep it from overflowing
	noPushWhenFull: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count < QueueDepth))
		else begin
			$error("push while prefetch queue full");
			failCount++;
		end

	creditsBounded: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= QueueDepth)
		else begin
			$error("fetch credits above queue depth");
			failCount++;
		end

	popOnlyWhenReady: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> (notEmpty && occupancy > 0))
		else begin
			$error("pop while prefetch queue empty");
			failCount++;
		end

endmodule

bind cpuCore cpuCore_checker #(
	.QueueDepth (QueueDepth)
) cpuCore_checker_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.push     (push),
	.pop      (pop),
	.notEmpty (notEmpty),
	.count    (prefetchQueue_inst.count),
	.credits  (fetchUnit_inst.credits)
);

`default_nettype wire

// ==== dv/cpuCoreTb.sv ====
// Testbench for the cut-down 6502 core
// Memory model, generated programs with a register model, and assertions
`default_nettype none

module cpuCoreTb
	import cpuIsaPkg::*;
	import cpuBusPkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int QueueDepth = 4;
	localparam int MaxInstr = 128;
	localparam logic [15:0] ProgBase = 16'h0400;

	logic clk;
	logic rst_n;
	logic fetchReq;
	logic memWrite;
	logic sync;
	logic [15:0] fetchAddr;
	logic [15:0] memAddr;
	logic [15:0] reqAddr;
	logic [7:0] fetchData;
	logic [7:0] memWData;
	logic [7:0] accDbg;
	logic [7:0] xDbg;
	logic [7:0] yDbg;
	logic [7:0] statusDbg;
	logic [7:0] mem [65536];
	logic [31:0] lfsr = 32'h4413;
	logic [7:0] mA;
	logic [7:0] mX;
	logic [7:0] mY;
	logic [7:0] mP;
	logic [7:0] expA [MaxInstr];
	logic [7:0] expX [MaxInstr];
	logic [7:0] expY [MaxInstr];
	logic [7:0] expP [MaxInstr];
	logic [7:0] stAddr [MaxInstr];
	logic [7:0] stData [MaxInstr];
	logic isStore [MaxInstr];
	int testOf [MaxInstr];
	int instrLen [MaxInstr];
	int expWrites [MaxInstr];
	int lastIdx [1:5];
	int errCount [1:5];
	string testName [1:5] = '{"resetVector", "loadsAndTransfers", "arithmeticFlags",
		"zeroPageStores", "fetchFlow"};
	opcode_t loadOps [15] = '{LDA_IMM, TAX, INX, LDY_IMM, TYA, DEY, TAY, LDX_IMM, TXA,
		DEX, INY, INX, LDA_IMM, TAY, DEY};
	opcode_t mixOps [8] = '{AND_IMM, NOP, ORA_IMM, INY, EOR_IMM, STA_ZP, TAX, DEX};
	int numInstr = 0;
	int pc = 0;
	int writesSoFar = 0;
	int cycleLimit = 1000000;
	int cycles = 0;
	int instrDone;
	int reqCount;
	int writeCount;
	int bytesDone;
	int lowInAlu;

	cpuCore #(.QueueDepth(QueueDepth)) cpuCore_inst (
		.clk(clk), .rst_n(rst_n), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.fetchData(fetchData), .memWrite(memWrite), .memAddr(memAddr),
		.memWData(memWData), .sync(sync), .accDbg(accDbg), .xDbg(xDbg),
		.yDbg(yDbg), .statusDbg(statusDbg)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory answers one cycle after the request, driven on the falling edge
	always @(posedge clk) begin
		reqAddr = fetchAddr;
		if (memWrite)
			mem[memAddr] = memWData;
	end

	always @(negedge clk)
		fetchData = mem[reqAddr];

	function automatic logic [7:0] randByte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	function automatic void setNZ(input logic [7:0] r);
		mP[FlagN] = r[7];
		mP[FlagZ] = (r == 8'h00);
	endfunction

	// Appends one instruction and steps the register model by 6502 rules
	task automatic addInstr(input opcode_t op, input int testId);
		logic [7:0] v;
		logic [7:0] r;
		logic [8:0] w;
		v = 8'h00;
		instrLen[numInstr] = 1;
		isStore[numInstr] = 1'b0;
		if (op inside {LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM,
				EOR_IMM, CMP_IMM, STA_ZP, STX_ZP, STY_ZP}) begin
			v = randByte();
			instrLen[numInstr] = 2;
		end
		case (op)
			LDA_IMM: begin
				mA = v;
				setNZ(mA);
			end
			LDX_IMM: begin
				mX = v;
				setNZ(mX);
			end
			LDY_IMM: begin
				mY = v;
				setNZ(mY);
			end
			ADC_IMM: begin
				w = mA + v + mP[FlagC];
				mP[FlagV] = (mA[7] == v[7]) && (w[7] != mA[7]);
				mP[FlagC] = w[8];
				mA = w[7:0];
				setNZ(mA);
			end
			SBC_IMM: begin
				// Carry clear means an extra borrow
				w = {1'b0, mA} - {1'b0, v} - {8'h00, ~mP[FlagC]};
				mP[FlagV] = (mA[7] != v[7]) && (w[7] != mA[7]);
				mP[FlagC] = ~w[8];
				mA = w[7:0];
				setNZ(mA);
			end
			AND_IMM: begin
				mA = mA & v;
				setNZ(mA);
			end
			ORA_IMM: begin
				mA = mA | v;
				setNZ(mA);
			end
			EOR_IMM: begin
				mA = mA ^ v;
				setNZ(mA);
			end
			CMP_IMM: begin
				r = mA - v;
				mP[FlagC] = (mA >= v);
				setNZ(r);
			end
			INX: begin
				mX = mX + 8'd1;
				setNZ(mX);
			end
			INY: begin
				mY = mY + 8'd1;
				setNZ(mY);
			end
			DEX: begin
				mX = mX - 8'd1;
				setNZ(mX);
			end
			DEY: begin
				mY = mY - 8'd1;
				setNZ(mY);
			end
			TAX: begin
				mX = mA;
				setNZ(mX);
			end
			TAY: begin
				mY = mA;
				setNZ(mY);
			end
			TXA: begin
				mA = mX;
				setNZ(mA);
			end
			TYA: begin
				mA = mY;
				setNZ(mA);
			end
			CLC: mP[FlagC] = 1'b0;
			SEC: mP[FlagC] = 1'b1;
			CLV: mP[FlagV] = 1'b0;
			STA_ZP, STX_ZP, STY_ZP: begin
				isStore[numInstr] = 1'b1;
				stAddr[numInstr] = v;
				stData[numInstr] = (op == STA_ZP) ? mA : ((op == STX_ZP) ? mX : mY);
				writesSoFar++;
			end
			default: ;
		endcase
		mem[ProgBase + pc] = op;
		if (instrLen[numInstr] == 2)
			mem[ProgBase + pc + 1] = v;
		pc += instrLen[numInstr];
		{expA[numInstr], expX[numInstr], expY[numInstr], expP[numInstr]} = {mA, mX, mY, mP};
		expWrites[numInstr] = writesSoFar;
		testOf[numInstr] = testId;
		lastIdx[testId] = numInstr;
		numInstr++;
	endtask

	function automatic int testAt(input int idx);
		return (idx < numInstr) ? testOf[idx] : 5;
	endfunction

	task automatic logMismatch(input string what, input int idx, input int e, input int a);
		errCount[testAt(idx)]++;
		$display("error %s: %s expected %0h actual %0h", testName[testAt(idx)], what, e, a);
	endtask

	task automatic flagFailure(input string what, input int idx);
		errCount[testAt(idx)]++;
		$display("%s failed: %s", testName[testAt(idx)], what);
	endtask

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{instrDone, reqCount, writeCount, bytesDone, lowInAlu} <= '0;
		end else begin
			reqCount <= reqCount + int'(fetchReq);
			writeCount <= writeCount + int'(memWrite);
			if (sync) begin
				instrDone <= instrDone + 1;
				if (instrDone < numInstr)
					bytesDone <= bytesDone + instrLen[instrDone];
			end
			if (!fetchReq && reqCount > 2 && testAt(instrDone) == 3)
				lowInAlu <= lowInAlu + 1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: program not finished after %0d cycles", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Register and flag state after each completed instruction
	accMatch: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone < numInstr) |-> accDbg == expA[instrDone])
		else logMismatch("A", $sampled(instrDone), expA[$sampled(instrDone)],
			$sampled(accDbg));
	xMatch: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone < numInstr) |-> xDbg == expX[instrDone])
		else logMismatch("X", $sampled(instrDone), expX[$sampled(instrDone)],
			$sampled(xDbg));
	yMatch: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone < numInstr) |-> yDbg == expY[instrDone])
		else logMismatch("Y", $sampled(instrDone), expY[$sampled(instrDone)],
			$sampled(yDbg));
	statusMatch: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone < numInstr) |-> statusDbg == expP[instrDone])
		else logMismatch("status", $sampled(instrDone), expP[$sampled(instrDone)],
			$sampled(statusDbg));
	statusAtReset: assert property (@(posedge clk) disable iff (!rst_n)
		(instrDone == 0 && !sync) |-> statusDbg == StatusReset)
		else logMismatch("reset status", 0, StatusReset, $sampled(statusDbg));

	vectorLo: assert property (@(posedge clk) disable iff (!rst_n)
		(fetchReq && reqCount == 0) |-> fetchAddr == ResetVectorLo)
		else logMismatch("first fetch", 0, ResetVectorLo, $sampled(fetchAddr));
	vectorHi: assert property (@(posedge clk) disable iff (!rst_n)
		(fetchReq && reqCount == 1) |-> fetchAddr == ResetVectorLo + 16'd1)
		else logMismatch("second fetch", 0, ResetVectorLo + 1, $sampled(fetchAddr));
	seqFetch: assert property (@(posedge clk) disable iff (!rst_n)
		(fetchReq && reqCount >= 2) |-> fetchAddr == 16'(ProgBase + reqCount - 2))
		else logMismatch("fetch address", $sampled(instrDone),
			16'(ProgBase + $sampled(reqCount) - 2), $sampled(fetchAddr));
	// Up to two bytes of the instruction under way are popped but not yet synced
	creditBound: assert property (@(posedge clk) disable iff (!rst_n)
		(fetchReq && reqCount >= 2 && instrDone < numInstr)
			|-> (reqCount - 1) <= bytesDone + QueueDepth + 2)
		else flagFailure("more fetches than credits allow", $sampled(instrDone));
	fetchStalls: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone == lastIdx[3]) |-> lowInAlu != 0)
		else flagFailure("fetchReq never dropped during ALU run", $sampled(instrDone));

	storeWrite: assert property (@(posedge clk) disable iff (!rst_n)
		(memWrite && instrDone < numInstr)
			|-> {isStore[instrDone], memAddr, memWData}
				== {1'b1, 8'h00, stAddr[instrDone], stData[instrDone]})
		else logMismatch("write addr/data", $sampled(instrDone),
			{8'h00, stAddr[$sampled(instrDone)], stData[$sampled(instrDone)]},
			{$sampled(memAddr), $sampled(memWData)});
	writeOnce: assert property (@(posedge clk) disable iff (!rst_n)
		(sync && instrDone < numInstr) |-> writeCount == expWrites[instrDone])
		else logMismatch("write count", $sampled(instrDone),
			expWrites[$sampled(instrDone)], $sampled(writeCount));

	initial begin
		int failed;
		int total;
		int protoErrors;
		rst_n = 1'b0;
		fetchData = 8'h00;
		reqAddr = 16'h0000;
		// Background depends on every address bit, program overwrites part of it
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
		mem[ResetVectorLo] = ProgBase[7:0];
		mem[ResetVectorLo + 1] = ProgBase[15:8];
		{mA, mX, mY, mP} = {24'h000000, StatusReset};
		foreach (errCount[t])
			errCount[t] = 0;
		addInstr(NOP, 1);
		addInstr(CLV, 1);
		foreach (loadOps[i])
			addInstr(loadOps[i], 2);
		for (int i = 0; i < 4; i++) begin
			addInstr(LDA_IMM, 3);
			addInstr((i % 2) ? SEC : CLC, 3);
			addInstr(ADC_IMM, 3);
			addInstr((i % 2) ? CLC : SEC, 3);
			addInstr(SBC_IMM, 3);
			addInstr(SEC, 3);
			addInstr(CMP_IMM, 3);
		end
		addInstr(CLV, 3);
		for (int i = 0; i < 3; i++) begin
			addInstr(LDA_IMM, 4);
			addInstr(STA_ZP, 4);
			addInstr(LDX_IMM, 4);
			addInstr(STX_ZP, 4);
			addInstr(LDY_IMM, 4);
			addInstr(STY_ZP, 4);
		end
		foreach (mixOps[i])
			addInstr(mixOps[i], 5);
		cycleLimit = 4 * pc + 100;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		failed = 0;
		total = 0;
		for (int t = 1; t <= 5; t++) begin
			while (instrDone <= lastIdx[t])
				@(negedge clk);
			$display("test %s finished with %0d errors", testName[t], errCount[t]);
			total += errCount[t];
			if (errCount[t] != 0)
				failed++;
		end
		// Queue and credit checker failures count against the run as well
		protoErrors = cpuCore_inst.cpuCore_checker_inst.failCount;
		$display("tests run 5, failed %0d, errors %0d, protocol errors %0d",
			failed, total, protoErrors);
		if (total == 0 && protoErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/cpuIsaPkg.sv
hdl/cpuBusPkg.sv
hdl/fetchUnit.sv
hdl/prefetchQueue.sv
hdl/alu.sv
hdl/execUnit.sv
hdl/cpuCore.sv
dv/cpuCore_checker.sv
dv/cpuCoreTb.sv
